// ==== design/mips_wb_pkg.sv ====
// Shared types and constants for the register-writeback subsystem.
// Register count and width are fixed by the MIPS instruction set.
// Memory words are big-endian: byte offset 0 is bits 31 down to 24.
// Byte-enable bit 3 covers bits 31 to 24, bit 0 covers bits 7 to 0.
package mips_wb_pkg;

    // architectural sizes
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int num_lanes  = word_w / 8;
    localparam int num_regs   = 32;

    // fixed register indices
    localparam int v0_index = 2;
    localparam int ra_index = 31;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [num_lanes-1:0]  byte_en_t;

    // multicycle core state, ALU results are only committed in exec
    typedef enum logic [1:0] {
        state_fetch  = 2'd0,
        state_decode = 2'd1,
        state_exec   = 2'd2,
        state_mem    = 2'd3
    } cpu_state_t;

    // load flavours handled by load_align
    // value 3'd7 is unused and produces no lane enables
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lbu = 3'd1,
        op_lh  = 3'd2,
        op_lhu = 3'd3,
        op_lw  = 3'd4,
        op_lwl = 3'd5,
        op_lwr = 3'd6
    } load_op_t;

    // all lanes written
    localparam byte_en_t be_full = '1;

    // no lanes written
    localparam byte_en_t be_none = '0;

endpackage

// ==== design/reg_write_if.sv ====
// One selected register write, from the write selection block to the
// register file. No handshake: a write with we high at a rising edge
// is taken at that edge. Byte enables act per 8-bit lane.
interface reg_write_if;

    // write request
    logic                   we;
    mips_wb_pkg::reg_addr_t addr;
    mips_wb_pkg::word_t     data;
    mips_wb_pkg::byte_en_t  be;

    // driven by write_select
    modport source (
        output we,
        output addr,
        output data,
        output be
    );

    // consumed by regfile
    modport sink (
        input we,
        input addr,
        input data,
        input be
    );

endinterface

// ==== design/load_align.sv ====
// Aligns a big-endian memory word into register write data and lane
// enables for lb, lbu, lh, lhu, lw, lwl and lwr. Purely combinational.
// Misaligned lh/lhu/lw are not detected: for halfwords only offset[1]
// is looked at, for lw the offset is ignored. The caller keeps them
// aligned. An unused op code gives no lane enables.
module load_align (
    input  mips_wb_pkg::word_t    rdata,
    input  logic [1:0]            offset,
    input  mips_wb_pkg::load_op_t op,
    output mips_wb_pkg::word_t    data,
    output mips_wb_pkg::byte_en_t be
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [4:0]  shift_left;
    logic [4:0]  shift_right;

    // byte k of a big-endian word sits at bits 31-8k down to 24-8k
    always_comb begin
        case (offset)
            2'd0:    sel_byte = rdata[31:24];
            2'd1:    sel_byte = rdata[23:16];
            2'd2:    sel_byte = rdata[15:8];
            default: sel_byte = rdata[7:0];
        endcase
    end

    // halfword at offset 0 is the upper half
    assign sel_half = offset[1] ? rdata[15:0] : rdata[31:16];

    // lwl moves byte k up to the top lane
    assign shift_left = {offset, 3'b000};

    // lwr moves byte k down to the bottom lane
    assign shift_right = {~offset, 3'b000};

    always_comb begin
        data = rdata;
        be   = mips_wb_pkg::be_full;
        case (op)
            mips_wb_pkg::op_lb: begin
                data = {{24{sel_byte[7]}}, sel_byte};
            end
            mips_wb_pkg::op_lbu: begin
                data = {24'd0, sel_byte};
            end
            mips_wb_pkg::op_lh: begin
                data = {{16{sel_half[15]}}, sel_half};
            end
            mips_wb_pkg::op_lhu: begin
                data = {16'd0, sel_half};
            end
            mips_wb_pkg::op_lw: begin
                data = rdata;
            end
            mips_wb_pkg::op_lwl: begin
                // bytes k..3 land in the top 4-k lanes
                data = rdata << shift_left;
                be   = mips_wb_pkg::be_full << offset;
            end
            mips_wb_pkg::op_lwr: begin
                // bytes 0..k land in the low k+1 lanes
                data = rdata >> shift_right;
                be   = mips_wb_pkg::be_full >> (2'd3 - offset);
            end
            default: begin
                be = mips_wb_pkg::be_none;
            end
        endcase
    end

endmodule

// ==== design/write_select.sv ====
// Picks the one source that writes the register file this cycle.
// Fixed priority: ALU, then load, then link. The ALU only counts in
// the exec state. A source that loses is dropped, not held; the caller
// presents it again if it still wants the write.
module write_select (
    input  mips_wb_pkg::cpu_state_t state,
    input  logic                    alu_we,
    input  mips_wb_pkg::word_t      alu_data,
    input  logic                    load_we,
    input  mips_wb_pkg::word_t      load_data,
    input  mips_wb_pkg::byte_en_t   load_be,
    input  logic                    link_we,
    input  logic                    link_to_ra,
    input  mips_wb_pkg::word_t      link_data,
    input  logic                    r_type,
    input  mips_wb_pkg::reg_addr_t  addr_rt,
    input  mips_wb_pkg::reg_addr_t  addr_rd,
    reg_write_if.source             wr
);

    logic alu_active;

    // ALU results are only valid once exec is reached
    assign alu_active = alu_we && (state == mips_wb_pkg::state_exec);

    always_comb begin
        wr.we   = 1'b0;
        wr.addr = '0;
        wr.data = '0;
        wr.be   = mips_wb_pkg::be_none;
        if (alu_active) begin
            wr.we   = 1'b1;
            wr.addr = r_type ? addr_rd : addr_rt;
            wr.data = alu_data;
            wr.be   = mips_wb_pkg::be_full;
        end else if (load_we) begin
            // loads always target rt, lanes come from load_align
            wr.we   = 1'b1;
            wr.addr = addr_rt;
            wr.data = load_data;
            wr.be   = load_be;
        end else if (link_we) begin
            wr.we   = 1'b1;
            wr.addr = link_to_ra ? mips_wb_pkg::reg_addr_t'(mips_wb_pkg::ra_index)
                                 : addr_rd;
            wr.data = link_data;
            wr.be   = mips_wb_pkg::be_full;
        end
    end

endmodule

// ==== design/regfile.sv ====
// 32 x 32 register file with per-lane writes.
// Two combinational read ports, both read zero for register 0.
// Writes to register 0 are dropped, so r0 stays zero in storage too.
// v0 is a registered copy of register 2 and lags it by one edge.
// Synchronous active-high reset clears every register and v0.
module regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_wb_pkg::reg_addr_t addr_rs,
    input  mips_wb_pkg::reg_addr_t addr_rt,
    output mips_wb_pkg::word_t     read_data_1,
    output mips_wb_pkg::word_t     read_data_2,
    output mips_wb_pkg::word_t     v0,
    reg_write_if.sink              wr
);

    mips_wb_pkg::word_t regs [mips_wb_pkg::num_regs];
    logic               wr_valid;

    // register 0 is hardwired, never written
    assign wr_valid = wr.we && (wr.addr != '0);

    // read ports
    always_comb begin
        if (addr_rs == '0) begin
            read_data_1 = '0;
        end else begin
            read_data_1 = regs[addr_rs];
        end
    end

    always_comb begin
        if (addr_rt == '0) begin
            read_data_2 = '0;
        end else begin
            read_data_2 = regs[addr_rt];
        end
    end

    // register array, each lane written on its own enable
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mips_wb_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            for (int b = 0; b < mips_wb_pkg::num_lanes; b++) begin
                if (wr.be[b]) begin
                    regs[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

    // v0 samples register 2 before this edge's write lands
    always_ff @(posedge clk) begin
        if (rst) begin
            v0 <= '0;
        end else begin
            v0 <= regs[mips_wb_pkg::v0_index];
        end
    end

endmodule

// ==== design/mips_wb_top.sv ====
// Register-writeback subsystem of a small multicycle MIPS core.
// Fetch, decode, ALU, memory and control live elsewhere; their results
// arrive here as plain ports. A write request in one cycle is readable
// on the read ports after the next rising edge, on v0 one edge later.
// Misaligned lh/lhu/lw must be avoided by the caller.
// Memory data is big-endian.
module mips_wb_top (
    input  logic                    clk,
    input  logic                    rst,
    input  mips_wb_pkg::reg_addr_t  addr_rs,
    input  mips_wb_pkg::reg_addr_t  addr_rt,
    input  mips_wb_pkg::reg_addr_t  addr_rd,
    input  logic                    r_type,
    input  mips_wb_pkg::cpu_state_t state,
    input  logic                    alu_we,
    input  mips_wb_pkg::word_t      alu_data,
    input  logic                    load_we,
    input  mips_wb_pkg::load_op_t   load_op,
    input  logic [1:0]              mem_offset,
    input  mips_wb_pkg::word_t      mem_rdata,
    input  logic                    link_we,
    input  logic                    link_to_ra,
    input  mips_wb_pkg::word_t      link_data,
    output mips_wb_pkg::word_t      read_data_1,
    output mips_wb_pkg::word_t      read_data_2,
    output mips_wb_pkg::word_t      v0
);

    mips_wb_pkg::word_t    load_data;
    mips_wb_pkg::byte_en_t load_be;

    // selected write, write_select to regfile
    reg_write_if wr_bus ();

    load_align u_load_align (
        .rdata  (mem_rdata),
        .offset (mem_offset),
        .op     (load_op),
        .data   (load_data),
        .be     (load_be)
    );

    write_select u_write_select (
        .state      (state),
        .alu_we     (alu_we),
        .alu_data   (alu_data),
        .load_we    (load_we),
        .load_data  (load_data),
        .load_be    (load_be),
        .link_we    (link_we),
        .link_to_ra (link_to_ra),
        .link_data  (link_data),
        .r_type     (r_type),
        .addr_rt    (addr_rt),
        .addr_rd    (addr_rd),
        .wr         (wr_bus.source)
    );

    regfile u_regfile (
        .clk         (clk),
        .rst         (rst),
        .addr_rs     (addr_rs),
        .addr_rt     (addr_rt),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .v0          (v0),
        .wr          (wr_bus.sink)
    );

endmodule

// ==== dv/tb_ref_model.svh ====
// Reference rules for the writeback testbench, included in the testbench
// module. Load results are rebuilt byte by byte from the big-endian
// rules. Misaligned lh/lhu/lw are never requested by the stimulus.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// expected register data and lanes for one load
function automatic void ref_load(
    input  mips_wb_pkg::word_t    rdata,
    input  logic [1:0]            offset,
    input  mips_wb_pkg::load_op_t op,
    output mips_wb_pkg::word_t    data,
    output mips_wb_pkg::byte_en_t be
);
    logic [7:0]  mb [4];
    logic [15:0] half;
    int          k;
    k = int'(offset);
    // memory byte i is the i-th byte from the top
    for (int i = 0; i < 4; i++) begin
        mb[i] = rdata[31-8*i -: 8];
    end
    half = {mb[k], mb[(k + 1) % 4]};
    data = '0;
    be   = '1;
    case (op)
        mips_wb_pkg::op_lb:  data = {{24{mb[k][7]}}, mb[k]};
        mips_wb_pkg::op_lbu: data = {24'd0, mb[k]};
        mips_wb_pkg::op_lh:  data = {{16{half[15]}}, half};
        mips_wb_pkg::op_lhu: data = {16'd0, half};
        mips_wb_pkg::op_lw:  data = rdata;
        mips_wb_pkg::op_lwl: begin
            be = '0;
            // register byte j from the top gets memory byte k+j
            for (int j = 0; j <= 3 - k; j++) begin
                data[31-8*j -: 8] = mb[k+j];
                be[3-j] = 1'b1;
            end
        end
        mips_wb_pkg::op_lwr: begin
            be = '0;
            // memory bytes 0..k fill the bottom k+1 register bytes
            for (int i = 0; i <= k; i++) begin
                data[31-8*(3-k+i) -: 8] = mb[i];
                be[k-i] = 1'b1;
            end
        end
        default: be = '0;
    endcase
endfunction

// model update, only the enabled lanes change
function automatic mips_wb_pkg::word_t merge_lanes(
    input mips_wb_pkg::word_t    old_val,
    input mips_wb_pkg::word_t    new_val,
    input mips_wb_pkg::byte_en_t be
);
    mips_wb_pkg::word_t r;
    r = old_val;
    for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
            r[8*b +: 8] = new_val[8*b +: 8];
        end
    end
    return r;
endfunction

// which source writes, where and with what
function automatic void ref_select(
    input  mips_wb_pkg::cpu_state_t state,
    input  logic                    alu_we,
    input  mips_wb_pkg::word_t      alu_data,
    input  logic                    load_we,
    input  mips_wb_pkg::word_t      load_data,
    input  mips_wb_pkg::byte_en_t   load_be,
    input  logic                    link_we,
    input  logic                    link_to_ra,
    input  mips_wb_pkg::word_t      link_data,
    input  logic                    r_type,
    input  mips_wb_pkg::reg_addr_t  addr_rt,
    input  mips_wb_pkg::reg_addr_t  addr_rd,
    output logic                    we,
    output mips_wb_pkg::reg_addr_t  addr,
    output mips_wb_pkg::word_t      data,
    output mips_wb_pkg::byte_en_t   be
);
    we   = 1'b1;
    addr = addr_rt;
    data = alu_data;
    be   = '1;
    if (alu_we && state == mips_wb_pkg::state_exec) begin
        addr = r_type ? addr_rd : addr_rt;
    end else if (load_we) begin
        data = load_data;
        be   = load_be;
    end else if (link_we) begin
        addr = link_to_ra ? 5'd31 : addr_rd;
        data = link_data;
    end else begin
        we = 1'b0;
    end
endfunction

`endif

// ==== dv/tb_mips_wb.sv ====
// Testbench for the writeback subsystem. Directed phases walk every
// source, state, load op and legal offset, then a random phase mixes
// them. The model follows the DUT edge by edge and a compare process
// checks both read ports and v0 one time unit before each rising edge.
module tb_mips_wb;

    localparam int rand_cycles = 2000;

    logic                    clk;
    logic                    rst;
    mips_wb_pkg::reg_addr_t  addr_rs;
    mips_wb_pkg::reg_addr_t  addr_rt;
    mips_wb_pkg::reg_addr_t  addr_rd;
    logic                    r_type;
    mips_wb_pkg::cpu_state_t state;
    logic                    alu_we;
    mips_wb_pkg::word_t      alu_data;
    logic                    load_we;
    mips_wb_pkg::load_op_t   load_op;
    logic [1:0]              mem_offset;
    mips_wb_pkg::word_t      mem_rdata;
    logic                    link_we;
    logic                    link_to_ra;
    mips_wb_pkg::word_t      link_data;
    mips_wb_pkg::word_t      read_data_1;
    mips_wb_pkg::word_t      read_data_2;
    mips_wb_pkg::word_t      v0;

    mips_wb_pkg::word_t model_regs [mips_wb_pkg::num_regs];
    mips_wb_pkg::word_t model_v0;
    logic [31:0]        lfsr_state;
    logic               check_en;
    int                 compare_count;

    `include "tb_ref_model.svh"

    mips_wb_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .addr_rs     (addr_rs),
        .addr_rt     (addr_rt),
        .addr_rd     (addr_rd),
        .r_type      (r_type),
        .state       (state),
        .alu_we      (alu_we),
        .alu_data    (alu_data),
        .load_we     (load_we),
        .load_op     (load_op),
        .mem_offset  (mem_offset),
        .mem_rdata   (mem_rdata),
        .link_we     (link_we),
        .link_to_ra  (link_to_ra),
        .link_data   (link_data),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .v0          (v0)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped after the first failure");
    endtask

    task automatic compare_word(
        input string              name,
        input mips_wb_pkg::word_t expected,
        input mips_wb_pkg::word_t actual
    );
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // model follows the inputs of the cycle each edge ends
    always @(posedge clk) begin
        logic                   we;
        mips_wb_pkg::reg_addr_t wa;
        mips_wb_pkg::word_t     wd;
        mips_wb_pkg::byte_en_t  wbe;
        mips_wb_pkg::word_t     ld;
        mips_wb_pkg::byte_en_t  lbe;
        if (rst) begin
            for (int i = 0; i < mips_wb_pkg::num_regs; i++) begin
                model_regs[i] = '0;
            end
            model_v0 = '0;
        end else begin
            ref_load(mem_rdata, mem_offset, load_op, ld, lbe);
            ref_select(state, alu_we, alu_data, load_we, ld, lbe, link_we, link_to_ra,
                       link_data, r_type, addr_rt, addr_rd, we, wa, wd, wbe);
            model_v0 = model_regs[mips_wb_pkg::v0_index];
            if (we && wa != 5'd0) begin
                model_regs[wa] = merge_lanes(model_regs[wa], wd, wbe);
            end
        end
    end

    // compare just before each rising edge
    initial begin
        forever begin
            @(posedge clk);
            #3;
            if (check_en) begin
                compare_word("read_data_1", (addr_rs == 5'd0) ? '0 : model_regs[addr_rs],
                             read_data_1);
                compare_word("read_data_2", (addr_rt == 5'd0) ? '0 : model_regs[addr_rt],
                             read_data_2);
                compare_word("v0", model_v0, v0);
                compare_count++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_enables();
        alu_we  = 1'b0;
        load_we = 1'b0;
        link_we = 1'b0;
    endtask

    // one write cycle, then one idle cycle showing the result
    task automatic alu_write(
        input int                     st,
        input logic                   rtype,
        input mips_wb_pkg::reg_addr_t rt,
        input mips_wb_pkg::reg_addr_t rd,
        input mips_wb_pkg::word_t     d
    );
        state    = mips_wb_pkg::cpu_state_t'(st);
        r_type   = rtype;
        addr_rt  = rt;
        addr_rd  = rd;
        addr_rs  = rd;
        alu_data = d;
        alu_we   = 1'b1;
        next_cycle();
        clear_enables();
        next_cycle();
    endtask

    task automatic load_to(
        input mips_wb_pkg::reg_addr_t rt,
        input int                     op,
        input int                     off,
        input mips_wb_pkg::word_t     w
    );
        state      = mips_wb_pkg::state_mem;
        addr_rt    = rt;
        addr_rs    = rt;
        load_op    = mips_wb_pkg::load_op_t'(op);
        mem_offset = 2'(off);
        mem_rdata  = w;
        load_we    = 1'b1;
        next_cycle();
        clear_enables();
        next_cycle();
    endtask

    task automatic random_cycle();
        logic [2:0] op_bits;
        state      = mips_wb_pkg::cpu_state_t'(2'(rand_bits(2)));
        alu_we     = 1'(rand_bits(1));
        load_we    = 1'(rand_bits(1));
        link_we    = 1'(rand_bits(1));
        link_to_ra = 1'(rand_bits(1));
        r_type     = 1'(rand_bits(1));
        addr_rs    = 5'(rand_bits(5));
        addr_rt    = 5'(rand_bits(5));
        addr_rd    = 5'(rand_bits(5));
        alu_data   = rand_bits(32);
        link_data  = rand_bits(32);
        mem_rdata  = rand_bits(32);
        mem_offset = 2'(rand_bits(2));
        op_bits    = 3'(rand_bits(3));
        // unused code 7 becomes lw
        // misaligned halfword and word loads are aligned
        load_op    = (op_bits == 3'd7) ? mips_wb_pkg::op_lw
                                       : mips_wb_pkg::load_op_t'(op_bits);
        if (load_op == mips_wb_pkg::op_lh || load_op == mips_wb_pkg::op_lhu) begin
            mem_offset[0] = 1'b0;
        end else if (load_op == mips_wb_pkg::op_lw) begin
            mem_offset = 2'd0;
        end
        next_cycle();
    endtask

    initial begin
        int target;
        int waited;
        rst           = 1'b1;
        check_en      = 1'b0;
        compare_count = 0;
        lfsr_state    = 32'h407f8e76;
        addr_rs       = '0;
        addr_rt       = '0;
        addr_rd       = '0;
        r_type        = 1'b0;
        state         = mips_wb_pkg::state_fetch;
        alu_data      = '0;
        load_op       = mips_wb_pkg::op_lw;
        mem_offset    = 2'd0;
        mem_rdata     = '0;
        link_to_ra    = 1'b0;
        link_data     = '0;
        clear_enables();
        for (int i = 0; i < mips_wb_pkg::num_regs; i++) begin
            model_regs[i] = '0;
        end
        model_v0 = '0;
        repeat (3) @(posedge clk);
        #1;
        rst      = 1'b0;
        check_en = 1'b1;

        // every register reads zero after reset
        for (int a = 0; a < mips_wb_pkg::num_regs; a++) begin
            addr_rs = 5'(a);
            addr_rt = 5'(31 - a);
            next_cycle();
        end

        // ALU in all states, rd and rt destinations, then r0 and v0
        for (int st = 0; st < 4; st++) begin
            alu_write(st, 1'b1, 5'd3, 5'd4, 32'h4400_0000 | st);
            alu_write(st, 1'b0, 5'd3, 5'd4, 32'h3300_0000 | st);
        end
        alu_write(2, 1'b0, 5'd0, 5'd5, 32'hdead_beef);
        alu_write(2, 1'b1, 5'd6, 5'd2, 32'h0bad_cafe);
        alu_write(2, 1'b0, 5'd2, 5'd0, 32'h1357_9bdf);

        // each load op at each legal offset over a known background
        for (int op = 0; op < 7; op++) begin
            for (int off = 0; off < 4; off++) begin
                if ((op == 2 || op == 3) && off[0]) continue;
                if (op == 4 && off != 0) continue;
                alu_write(2, 1'b0, 5'd7, 5'd0, 32'h1122_3344);
                load_to(5'd7, op, off, 32'h8a9b_7c6d);
            end
        end

        // unaligned word assembled from lwl then lwr
        alu_write(2, 1'b0, 5'd9, 5'd0, 32'hffff_ffff);
        load_to(5'd9, 5, 1, 32'h55aa_bbcc);
        load_to(5'd9, 6, 0, 32'hdd66_7788);

        // priority among two or three sources with the ALU gated by state
        for (int st = 0; st < 4; st++) begin
            for (int c = 1; c < 8; c++) begin
                state      = mips_wb_pkg::cpu_state_t'(st);
                alu_we     = c[0];
                load_we    = c[1];
                link_we    = c[2];
                r_type     = 1'b1;
                link_to_ra = 1'b0;
                addr_rt    = 5'd10;
                addr_rd    = 5'd11;
                addr_rs    = 5'd11;
                alu_data   = 32'ha000_0000 | c;
                load_op    = mips_wb_pkg::op_lw;
                mem_offset = 2'd0;
                mem_rdata  = 32'hb000_0000 | c;
                link_data  = 32'hc000_0000 | c;
                next_cycle();
                clear_enables();
                next_cycle();
            end
        end

        // link to ra and to rd
        for (int ra = 0; ra < 2; ra++) begin
            state      = mips_wb_pkg::state_decode;
            link_to_ra = ra[0];
            addr_rd    = 5'd12;
            addr_rs    = 5'd31;
            addr_rt    = 5'd12;
            link_data  = 32'h0040_0100 + ra;
            link_we    = 1'b1;
            next_cycle();
            clear_enables();
            next_cycle();
        end

        repeat (rand_cycles) random_cycle();
        clear_enables();

        // let the compare process see the last writes
        target = compare_count + 2;
        waited = 0;
        while (compare_count < target && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (compare_count < target) begin
            $display("Compare process made no progress within 20 cycles");
            abort_run();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
+incdir+dv
design/mips_wb_pkg.sv
design/reg_write_if.sv
design/load_align.sv
design/write_select.sv
design/regfile.sv
design/mips_wb_top.sv
dv/tb_mips_wb.sv
